//--- rtl/bundle_core_settings.svh
/* Bundle core settings */

`ifndef BUNDLE_CORE_SETTINGS_SVH
`define BUNDLE_CORE_SETTINGS_SVH

// Lanes per bundle
`define BC_LANES 4

// Architectural registers, 31 is the retire count
`define BC_REGS 32

`define BC_XLEN 32

// Predicate bits, index 3 does not exist
`define BC_PREDS 3

`define BC_APB_AW 8

`endif

//--- rtl/bundle_core_pkg.sv
/* Bundle core types and APB map */

`include "bundle_core_settings.svh"

package bundle_core_pkg;

   typedef enum logic [2:0] {
      op_nop = 3'd0,
      op_add = 3'd1,
      op_sub = 3'd2,
      op_and = 3'd3,
      op_xor = 3'd4,
      op_ldi = 3'd5,  // Immediate is {rs, rt}
      op_ceq = 3'd6,
      op_clt = 3'd7   // Unsigned
   } lane_opcode_e;

   typedef struct packed {
      logic                valid;
      lane_opcode_e        opcode;
      logic [4:0]          rd;
      logic [4:0]          rs;
      logic [4:0]          rt;
      logic [`BC_XLEN-1:0] rs_val;
      logic [`BC_XLEN-1:0] rt_val;
   } lane_op_t;

   typedef struct packed {
      logic                valid;    // Lane stage holds a bundle
      logic                rd_we;
      logic                pred_we;
      logic [4:0]          rd;
      logic [`BC_XLEN-1:0] data;
   } lane_result_t;

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [`BC_APB_AW-1:0] paddr;
      logic [`BC_XLEN-1:0]   pwdata;
   } apb_req_t;

   typedef struct packed {
      logic                pready;
      logic                pslverr;
      logic [`BC_XLEN-1:0] prdata;
   } apb_rsp_t;

   // Byte offsets
   localparam logic [`BC_APB_AW-1:0] apb_stage_base = 8'h00;
   localparam logic [`BC_APB_AW-1:0] apb_go         = 8'h10;
   localparam logic [`BC_APB_AW-1:0] apb_status     = 8'h14;
   localparam logic [`BC_APB_AW-1:0] apb_reg_base   = 8'h80;

endpackage

//--- rtl/bundle_apb_regs.sv
/* APB slave with staging and GO control */
`timescale 1ns/1ps

`include "bundle_core_settings.svh"

module bundle_apb_regs (
   input  logic                               clkrst_core_clk,
   input  logic                               clkrst_core_rst_n,
   input  bundle_core_pkg::apb_req_t          apb_req,
   output bundle_core_pkg::apb_rsp_t          apb_rsp,
   output logic [`BC_LANES-1:0][`BC_XLEN-1:0] stage_word,
   output logic                               go,
   input  logic                               done,
   output logic [4:0]                         host_num,
   input  logic [`BC_XLEN-1:0]                host_data,
   input  logic [`BC_PREDS-1:0]               preds
);
   import bundle_core_pkg::*;

   logic                  busy;
   logic                  access;
   logic [`BC_APB_AW-1:0] stage_off;
   logic [`BC_APB_AW-1:0] reg_off;
   logic                  stage_hit;
   logic                  go_hit;
   logic                  status_hit;
   logic                  reg_hit;
   logic                  wr_ok;
   logic                  rd_ok;

   assign access = apb_req.psel && apb_req.penable && !busy;  // Completing access cycle

   assign stage_off  = apb_req.paddr - apb_stage_base;
   assign reg_off    = apb_req.paddr - apb_reg_base;
   assign stage_hit  = (stage_off < (`BC_LANES * 4)) && (stage_off[1:0] == 2'b00);
   assign go_hit     = apb_req.paddr == apb_go;
   assign status_hit = apb_req.paddr == apb_status;
   assign reg_hit    = (apb_req.paddr >= apb_reg_base) && (reg_off[1:0] == 2'b00);

   assign wr_ok = apb_req.pwrite && (stage_hit || go_hit);
   assign rd_ok = !apb_req.pwrite && (status_hit || reg_hit);

   assign go       = access && apb_req.pwrite && go_hit;
   assign host_num = reg_off[6:2];

   always_comb begin
      apb_rsp.pready  = !busy;
      apb_rsp.pslverr = access && !(wr_ok || rd_ok);
      if (!apb_req.pwrite && status_hit) begin
         apb_rsp.prdata = {{(`BC_XLEN-`BC_PREDS){1'b0}}, preds};
      end else if (!apb_req.pwrite && reg_hit) begin
         apb_rsp.prdata = host_data;   // Combinational register read
      end else begin
         apb_rsp.prdata = '0;
      end
   end

   // Staging words reset to NOP
   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         stage_word <= '0;
      end else if (access && apb_req.pwrite && stage_hit) begin
         stage_word[stage_off[3:2]] <= apb_req.pwdata;
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         busy <= 1'b0;
      end else if (go) begin
         busy <= 1'b1;
      end else if (done) begin
         busy <= 1'b0;   // Bundle retires at this edge
      end
   end

   assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      apb_req.penable |-> apb_req.psel)
      else $error("APB penable without psel");

   // Stalled transfer must hold its request
   assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      apb_req.psel && apb_req.penable && !apb_rsp.pready |=> $stable(apb_req))
      else $error("APB request changed during wait");

endmodule

//--- rtl/core_regfile.sv
/* Eight-read four-write register file */
`timescale 1ns/1ps

`include "bundle_core_settings.svh"

module core_regfile (
   input  logic                                         clkrst_core_clk,
   input  logic                                         clkrst_core_rst_n,
   input  logic [`BC_LANES-1:0][4:0]                    rs_num,
   input  logic [`BC_LANES-1:0][4:0]                    rt_num,
   output logic [`BC_LANES-1:0][`BC_XLEN-1:0]           rs_data,
   output logic [`BC_LANES-1:0][`BC_XLEN-1:0]           rt_data,
   input  logic [4:0]                                   host_num,
   output logic [`BC_XLEN-1:0]                          host_data,
   input  bundle_core_pkg::lane_result_t [`BC_LANES-1:0] wr,
   input  logic [`BC_XLEN-1:0]                          r31,
   output logic [`BC_PREDS-1:0]                         preds
);
   import bundle_core_pkg::*;

   logic [`BC_XLEN-1:0]  mem [`BC_REGS];
   logic [`BC_LANES-1:0] pred_live;
   logic [`BC_PREDS-1:0] pred_hit;   // Bit named by some lane's predicate write

   // Predicate write that lands on an existing bit
   always_comb begin
      for (int i = 0; i < `BC_LANES; i++) begin
         pred_live[i] = wr[i].pred_we && (wr[i].rd[1:0] < `BC_PREDS);
      end
   end

   always_comb begin
      pred_hit = '0;
      for (int i = 0; i < `BC_LANES; i++) begin
         for (int j = 0; j < `BC_PREDS; j++) begin
            if (wr[i].pred_we && (wr[i].rd[1:0] == 2'(j))) begin
               pred_hit[j] = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int r = 0; r < `BC_REGS; r++) begin
            mem[r] <= '0;
         end
         preds <= '0;
      end else begin
         // Highest lane first so lane 0 has the final say
         for (int i = `BC_LANES - 1; i >= 0; i--) begin
            if (wr[i].rd_we) begin
               mem[wr[i].rd] <= wr[i].data;
            end
            if (pred_live[i]) begin
               preds[wr[i].rd[1:0]] <= wr[i].data[0];
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < `BC_LANES; i++) begin
         rs_data[i] = (&rs_num[i]) ? r31 : mem[rs_num[i]];
         rt_data[i] = (&rt_num[i]) ? r31 : mem[rt_num[i]];  // rt checks its own number
      end
   end

   assign host_data = (&host_num) ? r31 : mem[host_num];

   // Each predicate bit moves only on a write naming it, so index 3 touches none
   for (genvar j = 0; j < `BC_PREDS; j++) begin : g_pred_chk
      assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
         !pred_hit[j] |=> $stable(preds[j]))
         else $error("Predicate bit changed without a write to it");
   end

endmodule

//--- rtl/bundle_issue.sv
/* Bundle issue stage */
`timescale 1ns/1ps

`include "bundle_core_settings.svh"

module bundle_issue (
   input  logic                                      clkrst_core_clk,
   input  logic                                      clkrst_core_rst_n,
   input  logic                                      go,
   input  logic [`BC_LANES-1:0][`BC_XLEN-1:0]        stage_word,
   output logic [`BC_LANES-1:0][4:0]                 rs_num,
   output logic [`BC_LANES-1:0][4:0]                 rt_num,
   input  logic [`BC_LANES-1:0][`BC_XLEN-1:0]        rs_data,
   input  logic [`BC_LANES-1:0][`BC_XLEN-1:0]        rt_data,
   output bundle_core_pkg::lane_op_t [`BC_LANES-1:0] lane_op
);
   import bundle_core_pkg::*;

   lane_op_t [`BC_LANES-1:0] next_op;

   // Staging word fields
   always_comb begin
      for (int i = 0; i < `BC_LANES; i++) begin
         rs_num[i]         = stage_word[i][16:12];
         rt_num[i]         = stage_word[i][24:20];
         next_op[i].valid  = 1'b1;
         next_op[i].opcode = lane_opcode_e'(stage_word[i][2:0]);
         next_op[i].rd     = stage_word[i][8:4];
         next_op[i].rs     = rs_num[i];
         next_op[i].rt     = rt_num[i];
         next_op[i].rs_val = rs_data[i];
         next_op[i].rt_val = rt_data[i];
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         lane_op <= '0;
      end else begin
         for (int i = 0; i < `BC_LANES; i++) begin
            if (go) begin
               lane_op[i] <= next_op[i];
            end else begin
               lane_op[i].valid <= 1'b0;   // Only one cycle in this stage
            end
         end
      end
   end

endmodule

//--- rtl/lane_alu.sv
/* Lane execute stage */
`timescale 1ns/1ps

`include "bundle_core_settings.svh"

module lane_alu (
   input  logic                         clkrst_core_clk,
   input  logic                         clkrst_core_rst_n,
   input  bundle_core_pkg::lane_op_t    op,
   output bundle_core_pkg::lane_result_t result
);
   import bundle_core_pkg::*;

   lane_result_t nxt;

   always_comb begin
      nxt       = '0;
      nxt.valid = op.valid;
      nxt.rd    = op.rd;
      case (op.opcode)
         op_add:  nxt.data = op.rs_val + op.rt_val;
         op_sub:  nxt.data = op.rs_val - op.rt_val;
         op_and:  nxt.data = op.rs_val & op.rt_val;
         op_xor:  nxt.data = op.rs_val ^ op.rt_val;
         op_ldi:  nxt.data = {{(`BC_XLEN-10){1'b0}}, op.rs, op.rt};
         op_ceq:  nxt.data = {{(`BC_XLEN-1){1'b0}}, op.rs_val == op.rt_val};
         op_clt:  nxt.data = {{(`BC_XLEN-1){1'b0}}, op.rs_val < op.rt_val};
         default: nxt.data = '0;   // NOP
      endcase
      nxt.rd_we   = op.valid && (op.opcode inside {op_add, op_sub, op_and, op_xor, op_ldi});
      nxt.pred_we = op.valid && (op.opcode inside {op_ceq, op_clt});
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         result <= '0;
      end else begin
         result <= nxt;
      end
   end

endmodule

//--- rtl/bundle_writeback.sv
/* Bundle writeback and retire count */
`timescale 1ns/1ps

`include "bundle_core_settings.svh"

module bundle_writeback (
   input  logic                                          clkrst_core_clk,
   input  logic                                          clkrst_core_rst_n,
   input  bundle_core_pkg::lane_result_t [`BC_LANES-1:0] result,
   output bundle_core_pkg::lane_result_t [`BC_LANES-1:0] wr,
   output logic [`BC_XLEN-1:0]                           retire_count,
   output logic                                          done
);
   import bundle_core_pkg::*;

   logic [`BC_LANES-1:0] lane_valid;

   always_comb begin
      for (int i = 0; i < `BC_LANES; i++) begin
         lane_valid[i] = result[i].valid;
         wr[i]         = result[i];
      end
   end

   assign done = |lane_valid;   // Lane stage holds a bundle

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         retire_count <= '0;
      end else if (done) begin
         retire_count <= retire_count + 1'b1;
      end
   end

endmodule

//--- rtl/bundle_core.sv
/* Four-lane bundle core */
`timescale 1ns/1ps

`include "bundle_core_settings.svh"

module bundle_core (
   input  logic                      clkrst_core_clk,
   input  logic                      clkrst_core_rst_n,
   input  bundle_core_pkg::apb_req_t apb_req,
   output bundle_core_pkg::apb_rsp_t apb_rsp
);
   import bundle_core_pkg::*;

   logic [`BC_LANES-1:0][`BC_XLEN-1:0] stage_word;
   logic                               go;
   logic                               done;
   logic [4:0]                         host_num;
   logic [`BC_XLEN-1:0]                host_data;
   logic [`BC_PREDS-1:0]               preds;
   logic [`BC_LANES-1:0][4:0]          rs_num;
   logic [`BC_LANES-1:0][4:0]          rt_num;
   logic [`BC_LANES-1:0][`BC_XLEN-1:0] rs_data;
   logic [`BC_LANES-1:0][`BC_XLEN-1:0] rt_data;
   lane_op_t [`BC_LANES-1:0]           lane_op;
   lane_result_t [`BC_LANES-1:0]       lane_result;
   lane_result_t [`BC_LANES-1:0]       wr;
   logic [`BC_XLEN-1:0]                retire_count;

   bundle_apb_regs apb_regs_inst (
      .clkrst_core_clk  (clkrst_core_clk),
      .clkrst_core_rst_n(clkrst_core_rst_n),
      .apb_req          (apb_req),
      .apb_rsp          (apb_rsp),
      .stage_word       (stage_word),
      .go               (go),
      .done             (done),
      .host_num         (host_num),
      .host_data        (host_data),
      .preds            (preds)
   );

   bundle_issue issue_inst (
      .clkrst_core_clk  (clkrst_core_clk),
      .clkrst_core_rst_n(clkrst_core_rst_n),
      .go               (go),
      .stage_word       (stage_word),
      .rs_num           (rs_num),
      .rt_num           (rt_num),
      .rs_data          (rs_data),
      .rt_data          (rt_data),
      .lane_op          (lane_op)
   );

   for (genvar g = 0; g < `BC_LANES; g++) begin : g_lane
      lane_alu alu_inst (
         .clkrst_core_clk  (clkrst_core_clk),
         .clkrst_core_rst_n(clkrst_core_rst_n),
         .op               (lane_op[g]),
         .result           (lane_result[g])
      );
   end

   bundle_writeback writeback_inst (
      .clkrst_core_clk  (clkrst_core_clk),
      .clkrst_core_rst_n(clkrst_core_rst_n),
      .result           (lane_result),
      .wr               (wr),
      .retire_count     (retire_count),
      .done             (done)
   );

   core_regfile regfile_inst (
      .clkrst_core_clk  (clkrst_core_clk),
      .clkrst_core_rst_n(clkrst_core_rst_n),
      .rs_num           (rs_num),
      .rt_num           (rt_num),
      .rs_data          (rs_data),
      .rt_data          (rt_data),
      .host_num         (host_num),
      .host_data        (host_data),
      .wr               (wr),
      .r31              (retire_count),
      .preds            (preds)
   );

   // pready is low exactly while busy
   assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      done |-> !apb_rsp.pready)
      else $error("Bundle retired while not busy");

endmodule

//--- test/bundle_core_clkgen.sv
/* Testbench clock and reset */
`timescale 1ns/1ps

module bundle_core_clkgen #(
   parameter int unsigned period_ns    = 40,
   parameter int unsigned reset_cycles = 10
) (
   output logic clkrst_core_clk,
   output logic clkrst_core_rst_n
);

   initial begin
      clkrst_core_clk = 1'b0;
      forever #(period_ns / 2) clkrst_core_clk = ~clkrst_core_clk;
   end

   initial begin
      clkrst_core_rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clkrst_core_clk);
      #1 clkrst_core_rst_n = 1'b1;   // Released just after an edge
   end

endmodule

//--- test/bundle_core_tb.sv
/* Bundle core testbench */
`timescale 1ns/1ps

`include "bundle_core_settings.svh"

module bundle_core_tb;
   import bundle_core_pkg::*;

   localparam int unsigned timeout_cycles = 40 * 20 + 200;

   typedef logic [`BC_LANES-1:0][`BC_XLEN-1:0] bundle_t;

   logic                 clkrst_core_clk;
   logic                 clkrst_core_rst_n;
   apb_req_t             apb_req;
   apb_rsp_t             apb_rsp;
   logic                 xfer_done;
   logic [`BC_XLEN-1:0]  exp_data;
   logic                 exp_err;
   int unsigned          busy_left;
   int unsigned          cycle_count = 0;
   logic [31:0]          rng_state;
   logic [`BC_XLEN-1:0]  model_regs [`BC_REGS];
   logic [`BC_PREDS-1:0] model_preds;
   logic [`BC_XLEN-1:0]  model_retired;

   bundle_core_clkgen #(.period_ns(40), .reset_cycles(10)) clkgen_inst (
      .clkrst_core_clk  (clkrst_core_clk),
      .clkrst_core_rst_n(clkrst_core_rst_n)
   );

   bundle_core bundle_core_inst (
      .clkrst_core_clk  (clkrst_core_clk),
      .clkrst_core_rst_n(clkrst_core_rst_n),
      .apb_req          (apb_req),
      .apb_rsp          (apb_rsp)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped");
   endtask

   assign xfer_done = apb_req.psel && apb_req.penable && apb_rsp.pready;

   // A GO write keeps the core busy for the next two edges
   always @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         busy_left <= 0;
      end else if (xfer_done && apb_req.pwrite && apb_req.paddr == apb_go) begin
         busy_left <= 2;
      end else if (busy_left != 0) begin
         busy_left <= busy_left - 1;
      end
   end

   assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      apb_rsp.pready == (busy_left == 0))
      else abort_run($sformatf("mismatch: time %0t, pready against expected busy window",
                               $time));

   assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      xfer_done |-> apb_rsp.pslverr == exp_err)
      else abort_run($sformatf("mismatch: time %0t, pslverr %0b at address %h", $time,
                               apb_rsp.pslverr, apb_req.paddr));

   assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      xfer_done && !apb_req.pwrite && !exp_err |-> apb_rsp.prdata == exp_data)
      else abort_run($sformatf("mismatch: time %0t, read %h returned %h, expected %h", $time,
                               apb_req.paddr, apb_rsp.prdata, exp_data));

   always @(posedge clkrst_core_clk) cycle_count <= cycle_count + 1;

   initial begin
      wait (cycle_count >= timeout_cycles);
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", timeout_cycles));
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Staging word layout from the APB map
   function automatic logic [31:0] make_word(input lane_opcode_e op, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
      return {7'd0, rt, 3'd0, rs, 3'd0, rd, 1'b0, op};
   endfunction

   function automatic bundle_t make_bundle(input logic [31:0] l0, input logic [31:0] l1,
                                           input logic [31:0] l2, input logic [31:0] l3);
      return {l3, l2, l1, l0};
   endfunction

   function automatic logic [31:0] random_alu_word(input logic narrow);
      logic [31:0]  r;
      lane_opcode_e op;
      r = next_random();
      case (r[31:29])
         3'd0, 3'd5: op = op_ldi;
         3'd1, 3'd6: op = op_add;
         3'd2, 3'd7: op = op_sub;
         3'd3:       op = op_and;
         default:    op = op_xor;
      endcase
      // Narrow rd keeps lanes colliding
      return make_word(op, narrow ? {2'b00, r[26:24]} : r[28:24], r[21:17], r[16:12]);
   endfunction

   function automatic logic [31:0] random_pred_word();
      logic [31:0]  r;
      lane_opcode_e op;
      r = next_random();
      op = r[31] ? op_clt : op_ceq;
      return make_word(op, r[28:24], r[21:17], r[20] ? r[21:17] : r[14:10]);
   endfunction

   function automatic logic [`BC_XLEN-1:0] model_read(input logic [4:0] n);
      return (n == 5'd31) ? model_retired : model_regs[n];
   endfunction

   task automatic model_bundle(input bundle_t words);
      lane_opcode_e        op [`BC_LANES];
      logic [`BC_XLEN-1:0] val [`BC_LANES];
      logic [`BC_XLEN-1:0] a;
      logic [`BC_XLEN-1:0] b;
      for (int i = 0; i < `BC_LANES; i++) begin
         op[i] = lane_opcode_e'(words[i][2:0]);
         a     = model_read(words[i][16:12]);   // Operands see the state before the bundle
         b     = model_read(words[i][24:20]);
         case (op[i])
            op_add:  val[i] = a + b;
            op_sub:  val[i] = a - b;
            op_and:  val[i] = a & b;
            op_xor:  val[i] = a ^ b;
            op_ldi:  val[i] = {22'd0, words[i][16:12], words[i][24:20]};
            op_ceq:  val[i] = (a == b) ? 1 : 0;
            op_clt:  val[i] = (a < b) ? 1 : 0;
            default: val[i] = '0;
         endcase
      end
      for (int i = `BC_LANES - 1; i >= 0; i--) begin   // Lane 0 last, so it wins
         if (op[i] inside {op_add, op_sub, op_and, op_xor, op_ldi}) begin
            model_regs[words[i][8:4]] = val[i];
         end else if (op[i] inside {op_ceq, op_clt} && words[i][5:4] != 2'd3) begin
            model_preds[words[i][5:4]] = val[i][0];
         end
      end
      model_retired = model_retired + 1;
   endtask

   task automatic apb_transfer(input logic wr, input logic [`BC_APB_AW-1:0] addr,
                               input logic [`BC_XLEN-1:0] wdata,
                               input logic [`BC_XLEN-1:0] exp_val, input logic err);
      logic ready;
      apb_req  = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      exp_data = exp_val;
      exp_err  = err;
      @(posedge clkrst_core_clk);
      #1 apb_req.penable = 1'b1;
      do begin
         @(negedge clkrst_core_clk);
         ready = apb_rsp.pready;   // Mid-cycle, pready only moves at rising edges
         @(posedge clkrst_core_clk);
      end while (!ready);
      #1;
   endtask

   task automatic check_reg(input logic [4:0] n);
      apb_transfer(1'b0, apb_reg_base + {1'b0, n, 2'b00}, '0, model_read(n), 1'b0);
   endtask

   task automatic check_status();
      apb_transfer(1'b0, apb_status, '0, {{(`BC_XLEN-`BC_PREDS){1'b0}}, model_preds}, 1'b0);
   endtask

   task automatic run_bundle(input bundle_t words);
      for (int i = 0; i < `BC_LANES; i++) begin
         apb_transfer(1'b1, apb_stage_base + 8'(4 * i), words[i], '0, 1'b0);
      end
      model_bundle(words);
      apb_transfer(1'b1, apb_go, '0, '0, 1'b0);
      // First read is issued while the bundle is still in flight
      for (int i = 0; i < `BC_LANES; i++) begin
         check_reg(words[i][8:4]);
      end
      check_status();
   endtask

   initial begin
      bundle_t     w;
      logic [31:0] r;
      apb_req       = '0;
      exp_data      = '0;
      exp_err       = 1'b0;
      rng_state     = 32'h87a5c54e;
      model_preds   = '0;
      model_retired = '0;
      for (int n = 0; n < `BC_REGS; n++) model_regs[n] = '0;
      wait (clkrst_core_rst_n);
      @(posedge clkrst_core_clk);
      #1;

      for (int n = 0; n < `BC_REGS; n++) check_reg(5'(n));
      check_status();

      // Every register gets a random immediate
      for (int b = 0; b < 8; b++) begin
         for (int i = 0; i < `BC_LANES; i++) begin
            r    = next_random();
            w[i] = make_word(op_ldi, 5'(4 * b + i), r[31:27], r[26:22]);
         end
         run_bundle(w);
      end
      for (int b = 0; b < 10; b++) begin
         for (int i = 0; i < `BC_LANES; i++) w[i] = random_alu_word(b[0]);
         run_bundle(w);
      end

      // Shared destinations
      run_bundle(make_bundle(make_word(op_ldi, 7, 0, 11), make_word(op_ldi, 7, 0, 12),
                             make_word(op_ldi, 7, 0, 13), make_word(op_ldi, 7, 0, 14)));
      run_bundle(make_bundle(make_word(op_ldi, 10, 0, 5), make_word(op_ldi, 9, 0, 21),
                             make_word(op_ldi, 9, 0, 22), make_word(op_ldi, 9, 0, 23)));

      // Predicates, index 3 dropped, lane priority on one bit
      run_bundle(make_bundle(make_word(op_ldi, 1, 0, 5), make_word(op_ldi, 2, 0, 5),
                             make_word(op_ldi, 3, 0, 9), make_word(op_nop, 0, 0, 0)));
      run_bundle(make_bundle(make_word(op_ceq, 0, 1, 2), make_word(op_clt, 1, 3, 1),
                             make_word(op_clt, 2, 1, 3), make_word(op_nop, 0, 0, 0)));
      run_bundle(make_bundle(make_word(op_ceq, 3, 1, 2), make_word(op_ceq, 7, 1, 1),
                             make_word(op_nop, 0, 0, 0), make_word(op_ceq, 11, 2, 2)));
      run_bundle(make_bundle(make_word(op_clt, 1, 1, 3), make_word(op_ceq, 1, 1, 3),
                             make_word(op_ceq, 0, 1, 3), make_word(op_ceq, 0, 1, 3)));
      for (int b = 0; b < 4; b++) begin
         for (int i = 0; i < `BC_LANES; i++) w[i] = random_pred_word();
         run_bundle(w);
      end

      // Register 31 as a source and as a read
      run_bundle(make_bundle(make_word(op_add, 4, 31, 0), make_word(op_sub, 5, 2, 31),
                             make_word(op_xor, 6, 31, 31), make_word(op_and, 8, 31, 3)));
      check_reg(5'd31);

      // Unmapped and wrong-direction accesses
      apb_transfer(1'b0, 8'h18, '0, '0, 1'b1);
      apb_transfer(1'b0, 8'h00, '0, '0, 1'b1);
      apb_transfer(1'b0, 8'h81, '0, '0, 1'b1);
      apb_transfer(1'b1, apb_status, 32'h1, '0, 1'b1);
      apb_transfer(1'b1, 8'h84, 32'h1, '0, 1'b1);

      for (int n = 0; n < `BC_REGS; n++) check_reg(5'(n));
      check_status();
      apb_req = '0;
      repeat (3) @(posedge clkrst_core_clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- bundle_core.f
+incdir+rtl
rtl/bundle_core_pkg.sv
rtl/bundle_apb_regs.sv
rtl/core_regfile.sv
rtl/bundle_issue.sv
rtl/lane_alu.sv
rtl/bundle_writeback.sv
rtl/bundle_core.sv
test/bundle_core_clkgen.sv
test/bundle_core_tb.sv
